// ==== tb.f ====
+incdir+common
common/bus_types_pkg.sv
common/ctrl_types_pkg.sv
memory_controller/mc_arbiter.sv
memory_controller/mc_config_regs.sv
design/bus_bridge.sv
design/multicore_mem_top.sv
sim/tb_mem_model.sv
sim/tb_multicore_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_multicore_mem with Verilator, runs it, then scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_multicore_mem \
    --Mdir obj_dir -o sim_tb -f tb.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } || exit 0

// ==== sim/tb_multicore_mem.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module tb_multicore_mem
    import bus_types_pkg::*;
();
    localparam int NUM_HARTS    = 2;
    localparam int NUM_PORTS    = 2 * NUM_HARTS;
    localparam int PW           = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 20;
    localparam int ROW_CYCLES   = 64;
    localparam int DONE_TIMEOUT = 48;
    localparam int HOLD_CYCLES  = 16;

    // row operations
    localparam logic [2:0] OP_WRITE   = 3'd0;
    localparam logic [2:0] OP_READ    = 3'd1;
    localparam logic [2:0] OP_CFG_WR  = 3'd2;
    localparam logic [2:0] OP_CFG_RD  = 3'd3;
    localparam logic [2:0] OP_ABORT   = 3'd4;
    localparam logic [2:0] OP_BLOCKED = 3'd5;

    // port p uses addr + 16*p, data + p and expects exp_rdata + p
    typedef struct packed {
        logic [NUM_PORTS-1:0] mask;
        logic [2:0]           op;
        logic [31:0]          addr;
        logic [31:0]          data;
        logic [31:0]          exp_rdata;
        logic                 exp_err;
    } row_t;

    logic                           CLK;
    logic                           rst_n;
    fsb_req_t [NUM_PORTS-1:0]       port_req;
    logic [NUM_PORTS-1:0]           abort_bus;
    fsb_rsp_t [NUM_PORTS-1:0]       port_rsp;
    logic                           cfg_we;
    logic [`MC_CFG_ADDR_WIDTH-1:0]  cfg_addr;
    logic [`MC_DATA_WIDTH-1:0]      cfg_wdata;
    logic [`MC_DATA_WIDTH-1:0]      cfg_rdata;
    logic                           mem_ren;
    logic                           mem_wen;
    logic [`MC_ADDR_WIDTH-1:0]      mem_addr;
    logic [`MC_DATA_WIDTH-1:0]      mem_wdata;
    logic [`MC_DATA_WIDTH-1:0]      mem_rdata;
    logic                           mem_ready;
    logic [31:0]                    mem_accesses;

    row_t  table_rows [NUM_ROWS];
    string row_names [NUM_ROWS];
    int    n_rows;
    int    errors;
    int    checks;
    int    last_grant;

    multicore_mem_top #(
        .NUM_HARTS(NUM_HARTS)
    ) UUT (
        .CLK(CLK),
        .rst_n(rst_n),
        .port_req(port_req),
        .abort_bus(abort_bus),
        .port_rsp(port_rsp),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready)
    );

    tb_mem_model ext_mem (
        .CLK(CLK),
        .rst_n(rst_n),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .access_count(mem_accesses)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // run length bound from the table size
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_ROWS * ROW_CYCLES));
        $display("watchdog: run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_ROWS * ROW_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic compare_word(input string test, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: %s expected 0x%08h actual 0x%08h",
                     test, what, expected, actual);
        end
    endtask

    // round robin search starting just past the last granted port
    function automatic int expected_grant(input logic [NUM_PORTS-1:0] pending, input int last);
        int p;
        expected_grant = -1;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            p = (last + k) % NUM_PORTS;
            if (pending[PW'(p)] && expected_grant < 0) begin
                expected_grant = p;
            end
        end
    endfunction

    task automatic add_row(input string name, input logic [NUM_PORTS-1:0] mask,
                           input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp_rdata,
                           input logic exp_err);
        if (n_rows < NUM_ROWS) begin
            row_names[n_rows]  = name;
            table_rows[n_rows] = '{mask, op, addr, data, exp_rdata, exp_err};
        end
        n_rows++;
    endtask

    task automatic fill_table();
        // reset values of the register block
        add_row("reset_port_en", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_PORT_EN), 0, 32'hf, 0);
        add_row("reset_addr_limit", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_ADDR_LIMIT), 0,
                32'hffff_ffff, 0);
        add_row("reset_status", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_STATUS), 0, 0, 0);
        // write then read back with all four ports at once
        add_row("wr_all_ports", 4'b1111, OP_WRITE, 32'h100, 32'hcafe_0000, 0, 0);
        add_row("rd_port0", 4'b0001, OP_READ, 32'h100, 0, 32'hcafe_0000, 0);
        add_row("rd_port2", 4'b0100, OP_READ, 32'h100, 0, 32'hcafe_0000, 0);
        add_row("rr_read_all", 4'b1111, OP_READ, 32'h100, 0, 32'hcafe_0000, 0);
        // port 1 waits behind a cleared enable bit
        add_row("wr_port1", 4'b0010, OP_WRITE, 32'h200, 32'h5a5a_0000, 0, 0);
        add_row("mask_port1", 4'b0000, OP_CFG_WR, 32'(`MC_CFG_PORT_EN), 32'hd, 0, 0);
        add_row("blocked_port1", 4'b0010, OP_BLOCKED, 32'h200, 32'hf, 32'h5a5a_0000, 0);
        add_row("port_en_back", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_PORT_EN), 0, 32'hf, 0);
        // address limit error
        add_row("limit_set", 4'b0000, OP_CFG_WR, 32'(`MC_CFG_ADDR_LIMIT), 32'hfff, 0, 0);
        add_row("limit_read", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_ADDR_LIMIT), 0, 32'hfff, 0);
        add_row("rd_over_limit", 4'b0001, OP_READ, 32'h2000, 0, 0, 1);
        add_row("status_err_cnt", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_STATUS), 0, 32'h1, 0);
        add_row("limit_restore", 4'b0000, OP_CFG_WR, 32'(`MC_CFG_ADDR_LIMIT),
                32'hffff_ffff, 0, 0);
        // aborts before grant
        add_row("abort_port2", 4'b0100, OP_ABORT, 32'h100, 0, 0, 0);
        add_row("abort_ports01", 4'b0011, OP_ABORT, 32'h100, 0, 0, 0);
        add_row("rd_after_abort", 4'b0100, OP_READ, 32'h100, 0, 32'hcafe_0000, 0);
        add_row("status_final", 4'b0000, OP_CFG_RD, 32'(`MC_CFG_STATUS), 0, 32'h1, 0);
    endtask

    task automatic run_cfg(input int r);
        row_t row;
        row = table_rows[r];
        cfg_addr = row.addr[`MC_CFG_ADDR_WIDTH-1:0];
        if (row.op == OP_CFG_WR) begin
            cfg_wdata = row.data;
            cfg_we    = 1'b1;
            @(negedge CLK);
            cfg_we = 1'b0;
        end else begin
            @(negedge CLK);
            compare_word(row_names[r], "cfg_rdata", row.exp_rdata, cfg_rdata);
        end
    endtask

    // requests on every masked port and waits for each done
    task automatic run_access(input int r);
        row_t                 row;
        logic [NUM_PORTS-1:0] pending;
        logic [31:0]          count_before;
        int                   cycles;
        int                   g;
        row          = table_rows[r];
        pending      = row.mask;
        count_before = mem_accesses;
        cycles       = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (row.mask[PW'(p)]) begin
                port_req[PW'(p)].ren   = (row.op != OP_WRITE);
                port_req[PW'(p)].wen   = (row.op == OP_WRITE);
                port_req[PW'(p)].addr  = row.addr + 32'(16 * p);
                port_req[PW'(p)].wdata = row.data + 32'(p);
            end
        end
        while (pending != '0 && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            cfg_we = 1'b0;
            // a strobe belongs to the next port in rotation
            if (mem_ren || mem_wen) begin
                g = expected_grant(pending, last_grant);
                compare_word(row_names[r], "mem strobes",
                             (row.op == OP_WRITE) ? 32'd1 : 32'd2,
                             {30'b0, mem_ren, mem_wen});
                compare_word(row_names[r], "mem_addr", row.addr + 32'(16 * g), mem_addr);
                if (row.op == OP_WRITE) begin
                    compare_word(row_names[r], "mem_wdata", row.data + 32'(g), mem_wdata);
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (port_rsp[PW'(p)].done) begin
                    if (!pending[PW'(p)]) begin
                        report_error($sformatf("%s: done on port %0d with no request",
                                               row_names[r], p));
                    end else begin
                        if (row.op == OP_BLOCKED && cycles <= HOLD_CYCLES) begin
                            report_error($sformatf("%s: port %0d served while disabled",
                                                   row_names[r], p));
                        end
                        compare_word(row_names[r], "grant order",
                                     32'(expected_grant(pending, last_grant)), 32'(p));
                        compare_word(row_names[r], "error", 32'(row.exp_err),
                                     32'(port_rsp[PW'(p)].error));
                        if (row.op != OP_WRITE && !row.exp_err) begin
                            compare_word(row_names[r], "rdata", row.exp_rdata + 32'(p),
                                         port_rsp[PW'(p)].rdata);
                        end
                        port_req[PW'(p)] = '0;
                        pending[PW'(p)]  = 1'b0;
                        last_grant       = p;
                    end
                end else if (pending[PW'(p)] && !port_rsp[PW'(p)].dwait) begin
                    report_error($sformatf("%s: dwait low on pending port %0d",
                                           row_names[r], p));
                end
            end
            // mask comes back so the waiting port may go
            if (row.op == OP_BLOCKED && cycles == HOLD_CYCLES) begin
                cfg_addr  = `MC_CFG_PORT_EN;
                cfg_wdata = row.data;
                cfg_we    = 1'b1;
            end
        end
        cfg_we = 1'b0;
        if (pending != '0) begin
            report_error($sformatf("%s: no done on ports %b after %0d cycles",
                                   row_names[r], pending, cycles));
            port_req = '0;
        end
        // limit errors never reach the memory
        compare_word(row_names[r], "access count",
                     count_before + (row.exp_err ? 32'd0 : 32'($countones(row.mask))),
                     mem_accesses);
    endtask

    task automatic run_abort(input int r);
        row_t        row;
        logic [31:0] count_before;
        row          = table_rows[r];
        count_before = mem_accesses;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (row.mask[PW'(p)]) begin
                port_req[PW'(p)].ren  = 1'b1;
                port_req[PW'(p)].addr = row.addr + 32'(16 * p);
                abort_bus[PW'(p)]     = 1'b1;
            end
        end
        repeat (HOLD_CYCLES) begin
            @(negedge CLK);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (port_rsp[PW'(p)].done) begin
                    report_error($sformatf("%s: done on aborted port %0d", row_names[r], p));
                end
            end
            if (mem_ren || mem_wen) begin
                report_error($sformatf("%s: memory strobe during abort", row_names[r]));
            end
        end
        port_req  = '0;
        abort_bus = '0;
        compare_word(row_names[r], "access count", count_before, mem_accesses);
    endtask

    initial begin
        port_req   = '0;
        abort_bus  = '0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        rst_n      = 1'b0;
        errors     = 0;
        checks     = 0;
        n_rows     = 0;
        // reset pointer starts the search at port 0
        last_grant = NUM_PORTS - 1;
        fill_table();
        if (n_rows != NUM_ROWS) begin
            report_error($sformatf("table holds %0d rows, sized for %0d", n_rows, NUM_ROWS));
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        @(negedge CLK);
        // quiet outputs straight out of reset
        for (int p = 0; p < NUM_PORTS; p++) begin
            compare_word("reset_outputs", $sformatf("done port %0d", p), 0,
                         32'(port_rsp[PW'(p)].done));
        end
        compare_word("reset_outputs", "mem strobes", 0, {30'b0, mem_ren, mem_wen});
        for (int r = 0; r < NUM_ROWS && r < n_rows; r++) begin
            case (table_rows[r].op)
                OP_CFG_WR, OP_CFG_RD: run_cfg(r);
                OP_ABORT:             run_abort(r);
                default:              run_access(r);
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module tb_mem_model #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  logic [`MC_ADDR_WIDTH-1:0] mem_addr,
    input  logic [`MC_DATA_WIDTH-1:0] mem_wdata,
    output logic [`MC_DATA_WIDTH-1:0] mem_rdata,
    output logic                      mem_ready,
    output logic [31:0]               access_count
);
    // reference array, word addressed
    logic [`MC_DATA_WIDTH-1:0] mem [0:(1 << DEPTH_LOG2)-1];
    logic [DEPTH_LOG2-1:0]     idx;
    logic                      started;
    int                        wait_left;
    int                        seed;

    assign idx = mem_addr[DEPTH_LOG2+1:2];

    // fill pattern built from every index bit
    initial begin
        seed = 32'hceb5;
        for (int i = 0; i < (1 << DEPTH_LOG2); i++) begin
            mem[i] = {i[15:0] ^ 16'h3c5a, ~i[15:0]};
        end
    end

    always @(posedge CLK) begin
        if (!rst_n) begin
            mem_ready    <= 1'b0;
            mem_rdata    <= '0;
            access_count <= '0;
            started      = 1'b0;
            wait_left    = 0;
        end else begin
            mem_ready <= 1'b0;
            // strobe seen, and not the cycle ready is already up
            if ((mem_ren || mem_wen) && !mem_ready) begin
                if (!started) begin
                    // 0 to 3 wait states per access
                    started   = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    started      = 1'b0;
                    mem_ready    <= 1'b1;
                    access_count <= access_count + 1;
                    if (mem_wen) begin
                        mem[idx] = mem_wdata;
                    end else begin
                        mem_rdata <= mem[idx];
                    end
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

// ==== design/multicore_mem_top.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module multicore_mem_top
    import bus_types_pkg::*, ctrl_types_pkg::*;
#(
    parameter int NUM_HARTS = `MC_NUM_HARTS
) (
    input  logic                          CLK,
    input  logic                          rst_n,
    input  fsb_req_t [2*NUM_HARTS-1:0]    port_req,
    input  logic [2*NUM_HARTS-1:0]        abort_bus,
    output fsb_rsp_t [2*NUM_HARTS-1:0]    port_rsp,
    input  logic                          cfg_we,
    input  logic [`MC_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [`MC_DATA_WIDTH-1:0]     cfg_wdata,
    output logic [`MC_DATA_WIDTH-1:0]     cfg_rdata,
    output logic                          mem_ren,
    output logic                          mem_wen,
    output logic [`MC_ADDR_WIDTH-1:0]     mem_addr,
    output logic [`MC_DATA_WIDTH-1:0]     mem_wdata,
    input  logic [`MC_DATA_WIDTH-1:0]     mem_rdata,
    input  logic                          mem_ready
);
    // controller to bridge
    gbus_req_t gbus_req;
    gbus_rsp_t gbus_rsp;

    // register block steering
    mc_cfg_t   cfg;
    logic      arb_busy;
    logic      err_pulse;

    mc_arbiter #(
        .NUM_HARTS(NUM_HARTS)
    ) mc (
        .CLK(CLK),
        .rst_n(rst_n),
        .port_req(port_req),
        .abort_bus(abort_bus),
        .cfg(cfg),
        .gbus_rsp(gbus_rsp),
        .port_rsp(port_rsp),
        .gbus_req(gbus_req),
        .busy(arb_busy),
        .err_pulse(err_pulse)
    );

    mc_config_regs #(
        .NUM_HARTS(NUM_HARTS)
    ) regs (
        .CLK(CLK),
        .rst_n(rst_n),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .busy(arb_busy),
        .err_pulse(err_pulse),
        .cfg_rdata(cfg_rdata),
        .cfg(cfg)
    );

    bus_bridge bt (
        .CLK(CLK),
        .rst_n(rst_n),
        .gbus_req(gbus_req),
        .cfg(cfg),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .gbus_rsp(gbus_rsp),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

endmodule

// ==== design/bus_bridge.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module bus_bridge
    import bus_types_pkg::*, ctrl_types_pkg::*;
(
    input  logic                      CLK,
    input  logic                      rst_n,
    input  gbus_req_t                 gbus_req,
    input  mc_cfg_t                   cfg,
    input  logic [`MC_DATA_WIDTH-1:0] mem_rdata,
    input  logic                      mem_ready,
    output gbus_rsp_t                 gbus_rsp,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output logic [`MC_ADDR_WIDTH-1:0] mem_addr,
    output logic [`MC_DATA_WIDTH-1:0] mem_wdata
);
    typedef enum logic {
        IDLE   = 1'b0,
        ACCESS = 1'b1
    } br_state_t;

    br_state_t                 state;
    logic                      busy_q;
    logic                      error_q;
    logic                      cmpl_q;
    logic [`MC_DATA_WIDTH-1:0] rdata_q;
    logic                      req_vld;
    logic                      over_limit;
    logic                      start;

    assign req_vld    = gbus_req.ren | gbus_req.wen;
    assign over_limit = gbus_req.addr > cfg.addr_limit;

    // cmpl_q masks the old request still held in the release cycle
    assign start = (state == IDLE) && req_vld && !busy_q && !cmpl_q;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state   <= IDLE;
            busy_q  <= 1'b0;
            error_q <= 1'b0;
            cmpl_q  <= 1'b0;
        end else begin
            cmpl_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (busy_q) begin
                        // limit error, one busy cycle and no strobe
                        busy_q <= 1'b0;
                        cmpl_q <= 1'b1;
                    end else if (start) begin
                        busy_q  <= 1'b1;
                        error_q <= over_limit;
                        if (!over_limit) begin
                            state <= ACCESS;
                        end
                    end
                end
                ACCESS: begin
                    if (mem_ready) begin
                        state  <= IDLE;
                        busy_q <= 1'b0;
                        cmpl_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read data taken with mem_ready, disabled lanes zeroed
    always_ff @(posedge CLK) begin
        if (state == ACCESS && mem_ready && gbus_req.ren) begin
            for (int b = 0; b < `MC_BE_WIDTH; b++) begin
                rdata_q[b*8 +: 8] <= gbus_req.byte_en[b] ? mem_rdata[b*8 +: 8] : 8'h00;
            end
        end
    end

    // strobes held for the whole access
    assign mem_ren   = (state == ACCESS) & gbus_req.ren;
    assign mem_wen   = (state == ACCESS) & gbus_req.wen;
    assign mem_addr  = gbus_req.addr;
    assign mem_wdata = gbus_req.wdata;

    always_comb begin
        gbus_rsp.busy  = busy_q;
        gbus_rsp.rdata = rdata_q;
        gbus_rsp.error = error_q;
    end

    a_one_strobe: assert property (@(posedge CLK) disable iff (!rst_n)
        !(mem_ren && mem_wen));

    // a strobe waits for the memory
    a_strobe_held: assert property (@(posedge CLK) disable iff (!rst_n)
        (mem_ren || mem_wen) && !mem_ready |=> (mem_ren || mem_wen));

endmodule

// ==== memory_controller/mc_config_regs.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_config_regs
    import ctrl_types_pkg::*;
#(
    parameter int NUM_HARTS = `MC_NUM_HARTS
) (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic [`MC_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [`MC_DATA_WIDTH-1:0]    cfg_wdata,
    input  logic                         busy,
    input  logic                         err_pulse,
    output logic [`MC_DATA_WIDTH-1:0]    cfg_rdata,
    output mc_cfg_t                      cfg
);
    localparam int NUM_PORTS = 2 * NUM_HARTS;

    logic [NUM_PORTS-1:0]        port_en_q;
    logic [`MC_ADDR_WIDTH-1:0]   addr_limit_q;
    logic [`MC_ERR_CNT_WIDTH-1:0] err_cnt_q;

    // mask field in mc_cfg_t is sized for the default hart count
    if (NUM_HARTS > `MC_NUM_HARTS) begin : g_size_check
        $error("mc_config_regs: NUM_HARTS exceeds port_en width in mc_cfg_t");
    end

    // writable registers, new value seen next cycle
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            port_en_q    <= '1;
            addr_limit_q <= '1;
        end else if (cfg_we) begin
            case (cfg_addr)
                `MC_CFG_PORT_EN:    port_en_q    <= cfg_wdata[NUM_PORTS-1:0];
                `MC_CFG_ADDR_LIMIT: addr_limit_q <= cfg_wdata[`MC_ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // error completions, saturating
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            err_cnt_q <= '0;
        end else if (err_pulse && !(&err_cnt_q)) begin
            err_cnt_q <= err_cnt_q + 1'b1;
        end
    end

    // read mux
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            `MC_CFG_PORT_EN:    cfg_rdata[NUM_PORTS-1:0] = port_en_q;
            `MC_CFG_ADDR_LIMIT: cfg_rdata[`MC_ADDR_WIDTH-1:0] = addr_limit_q;
            `MC_CFG_STATUS: begin
                cfg_rdata[`MC_STAT_BUSY_BIT] = busy;
                cfg_rdata[`MC_ERR_CNT_WIDTH-1:0] = err_cnt_q;
            end
            default: cfg_rdata = '0;
        endcase
    end

    // unused upper mask bits stay clear
    always_comb begin
        cfg = '0;
        cfg.port_en[NUM_PORTS-1:0] = port_en_q;
        cfg.addr_limit = addr_limit_q;
    end

endmodule

// ==== memory_controller/mc_arbiter.sv ====
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_arbiter
    import bus_types_pkg::*, ctrl_types_pkg::*;
#(
    parameter int NUM_HARTS = `MC_NUM_HARTS
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  fsb_req_t [2*NUM_HARTS-1:0] port_req,
    input  logic [2*NUM_HARTS-1:0]     abort_bus,
    input  mc_cfg_t                    cfg,
    input  gbus_rsp_t                  gbus_rsp,
    output fsb_rsp_t [2*NUM_HARTS-1:0] port_rsp,
    output gbus_req_t                  gbus_req,
    output logic                       busy,
    output logic                       err_pulse
);
    localparam int NUM_PORTS = 2 * NUM_HARTS;
    localparam int PW = $clog2(NUM_PORTS);

    logic [NUM_PORTS-1:0]      req_vec;
    logic [NUM_PORTS-1:0]      eligible;
    logic [NUM_PORTS-1:0]      done_vec;
    logic [PW-1:0]             rr_ptr;
    logic [PW-1:0]             pick_idx;
    logic                      pick_vld;
    logic [PW-1:0]             grant_idx;
    logic                      active;
    logic                      seen_busy;
    logic                      cmpl;
    l2_state_t                 l2_state;
    logic                      lat_ren;
    logic                      lat_wen;
    logic [`MC_ADDR_WIDTH-1:0] lat_addr;
    logic [`MC_DATA_WIDTH-1:0] lat_wdata;

    // requesting, enabled and not aborted
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            req_vec[i]  = port_req[i].ren | port_req[i].wen;
            eligible[i] = req_vec[i] & cfg.port_en[i] & ~abort_bus[i];
        end
    end

    // rotating search from rr_ptr where the first hit wins
    always_comb begin
        int idx;
        idx = 0;
        pick_vld = 1'b0;
        pick_idx = '0;
        for (int off = 0; off < NUM_PORTS; off++) begin
            idx = int'(rr_ptr) + off;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (eligible[idx] && !pick_vld) begin
                pick_vld = 1'b1;
                pick_idx = PW'(idx);
            end
        end
    end

    assign l2_state = gbus_rsp.busy ? L2_BUSY : L2_ACCESS;

    // bridge raises busy a cycle late, so only a fall after a rise ends it
    assign cmpl = active && seen_busy && (l2_state == L2_ACCESS);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            active    <= 1'b0;
            seen_busy <= 1'b0;
            rr_ptr    <= '0;
            grant_idx <= '0;
        end else if (cmpl) begin
            active    <= 1'b0;
            seen_busy <= 1'b0;
        end else if (active) begin
            if (l2_state == L2_BUSY) begin
                seen_busy <= 1'b1;
            end
        end else if (pick_vld) begin
            active    <= 1'b1;
            grant_idx <= pick_idx;
            // next search starts just past the winner
            rr_ptr    <= (int'(pick_idx) == NUM_PORTS - 1) ? '0 : pick_idx + 1'b1;
        end
    end

    // request copy taken at grant
    always_ff @(posedge CLK) begin
        if (!active && pick_vld) begin
            lat_wen   <= port_req[pick_idx].wen;
            // write wins if a port raises both
            lat_ren   <= port_req[pick_idx].ren & ~port_req[pick_idx].wen;
            lat_addr  <= port_req[pick_idx].addr;
            lat_wdata <= port_req[pick_idx].wdata;
        end
    end

    always_comb begin
        gbus_req.ren     = active & lat_ren;
        gbus_req.wen     = active & lat_wen;
        gbus_req.addr    = lat_addr;
        gbus_req.wdata   = lat_wdata;
        // whole words only on the front side
        gbus_req.byte_en = '1;
    end

    // response routing to the granted port
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            done_vec[i]       = cmpl && (grant_idx == PW'(i));
            port_rsp[i].done  = done_vec[i];
            port_rsp[i].dwait = (port_req[i].ren | port_req[i].wen) & ~done_vec[i];
            port_rsp[i].rdata = (grant_idx == PW'(i)) ? gbus_rsp.rdata : '0;
            port_rsp[i].error = done_vec[i] & gbus_rsp.error;
        end
    end

    assign busy      = active;
    assign err_pulse = cmpl & gbus_rsp.error;

    // one done at a time and only to a port that held its request
    a_one_done: assert property (@(posedge CLK) disable iff (!rst_n)
        $onehot0(done_vec) && ((done_vec & ~$past(req_vec)) == '0));

    // request must not move under the bridge
    a_req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        gbus_rsp.busy |=> $stable(gbus_req));

endmodule

// ==== common/ctrl_types_pkg.sv ====
`include "mc_defs.svh"

package ctrl_types_pkg;

    // generic bus state as seen by the controller
    typedef enum logic {
        L2_ACCESS = 1'b0,
        L2_BUSY   = 1'b1
    } l2_state_t;

    // configuration that steers the datapath
    // port_en sized for the default hart count
    typedef struct packed {
        logic [2*`MC_NUM_HARTS-1:0] port_en;
        logic [`MC_ADDR_WIDTH-1:0]  addr_limit;
    } mc_cfg_t;

endpackage

// ==== common/bus_types_pkg.sv ====
`include "mc_defs.svh"

package bus_types_pkg;

    // front-side request, held as a level until done
    typedef struct packed {
        logic                      ren;
        logic                      wen;
        logic [`MC_ADDR_WIDTH-1:0] addr;
        logic [`MC_DATA_WIDTH-1:0] wdata;
    } fsb_req_t;

    // front-side response
    // dwait is a level, done a single-cycle pulse
    typedef struct packed {
        logic                      dwait;
        logic                      done;
        logic [`MC_DATA_WIDTH-1:0] rdata;
        logic                      error;
    } fsb_rsp_t;

    // generic bus request toward the bridge
    typedef struct packed {
        logic                      ren;
        logic                      wen;
        logic [`MC_ADDR_WIDTH-1:0] addr;
        logic [`MC_DATA_WIDTH-1:0] wdata;
        logic [`MC_BE_WIDTH-1:0]   byte_en;
    } gbus_req_t;

    // generic bus response
    // rdata and error valid in the cycle busy falls
    typedef struct packed {
        logic                      busy;
        logic [`MC_DATA_WIDTH-1:0] rdata;
        logic                      error;
    } gbus_rsp_t;

endpackage

// ==== common/mc_defs.svh ====
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// bus widths
`define MC_DATA_WIDTH 32
`define MC_ADDR_WIDTH 32

// one enable per data byte
`define MC_BE_WIDTH (`MC_DATA_WIDTH / 8)

// default hart count, each hart owns an icache and a dcache port
`define MC_NUM_HARTS 2

// config register word offsets
`define MC_CFG_ADDR_WIDTH 2
`define MC_CFG_PORT_EN    2'd0
`define MC_CFG_ADDR_LIMIT 2'd1
`define MC_CFG_STATUS     2'd2

// status word layout
`define MC_STAT_BUSY_BIT 16
`define MC_ERR_CNT_WIDTH 16

`endif
